// ==== testbench/ifu_patterns.txt ====
// @00 test count, then per line: start byte address, flush kind (0 flush, 1 halt first),
// consume mode (0 by two, 1 by one, 2 random, 3 held), expected word count
// @20 first 16 ICCM words, @30 bus window base address and its 16 words
@00
00000006
EE000000 0 0 0C
20000100 0 1 06
EE000046 0 2 0A
EE000080 0 3 08
80000040 1 2 06
EE0003F0 0 0 08
@20
00000013 00100093 00200113 002081B3
40110233 0041A2A3 00C000EF 0062E333
FE5212E3 00008067 123452B7 FFF28293
00531463 0000006F 00A00513 00000073
@30
20000100
C0DE0001 C0DE0102 C0DE0203 C0DE0304
B0BA0405 B0BA0506 B0BA0607 B0BA0708
D00D0809 D00D090A D00D0A0B D00D0B0C
F1E20C0D F1E20D0E F1E20E0F F1E20F10

// ==== sources.f ====
rtl/ifu_pkg.sv
rtl/ifu_fetch_ctl.sv
rtl/ifu_mem_stage.sv
rtl/ifu_miss_buf.sv
rtl/ifu_fetch_buf.sv
rtl/ifu_top.sv
testbench/tb_ifu_top.sv

// ==== testbench/tb_ifu_top.sv ====
`timescale 1ns/10ps
// Self-checking testbench for the instruction fetch front end
// Loads the ICCM through its write port, answers bus reads from the bus image,
// then runs each test record as a flush plus an aligner stream and checks every word

module tb_ifu_top;
   import ifu_pkg::*;

   logic        clk = 1'b0;
   logic        rst_n, flush, flush_noredir, fb_consume1, fb_consume2;
   fetch_addr_t flush_path, fb_addr0, fb_addr1;
   logic [31:0] mrac, bus_addr;
   logic        iccm_wr_en, bus_rvalid, bus_req, fb_fault0, fb_fault1;
   iccm_idx_t   iccm_wr_addr;
   inst_word_t  iccm_wr_data, bus_rdata, fb_data0, fb_data1;
   logic [1:0]  fb_valid;
   logic        fetch_uncacheable_bf, pmu_fetch_stall;

   logic [31:0] pat [0:79];                  // Raw patterns file image
   inst_word_t  iccm_img [ICCM_SIZE_WORDS];
   int          errors = 0;
   int          checks = 0;
   int          wd_cycles = 0;
   logic [31:0] t_start = ICCM_SADR;         // Bus requests flagged until a bus test runs
   int          t_kind, t_mode, t_count;
   string       t_name;
   logic [31:0] exp_addr, req_addr;          // Next word to consume, next word to request
   bit          halted = 1'b0;
   bit          bus_busy = 1'b0;
   int          bus_wait;
   logic [31:0] bus_pend;

   always #2 clk = ~clk;                     // 4 ns period

   ifu_top dut_i (.*);

   // ****************************************
   // Reference model of the images
   // ****************************************
   // Filler for the words that the patterns file leaves open
   function automatic logic [31:0] fill_word(logic [31:0] a);
      return {a[15:0], a[31:16]} ^ 32'h5A5A_A5A5;
   endfunction

   function automatic logic [31:0] next_addr(logic [31:0] a);
      logic [31:0] n;
      n = {a[31:2] + 30'd1, a[1:0]};
      if (n[LINE_INDEX_LO] != a[LINE_INDEX_LO])
         n[1] = 1'b0;                        // New line starts word aligned
      return n;
   endfunction

   function automatic logic [31:0] bus_word(logic [31:0] a);
      logic [31:0] off;
      off = ({a[31:2], 2'b00} - pat[48]) >> 2;
      if (off < 16)
         return pat[49 + off];               // Inside the window from the file
      return fill_word({a[31:2], 2'b00});
   endfunction

   // ICCM spans ICCM_SIZE_WORDS words upward from its start address
   function automatic bit in_iccm(logic [31:0] a);
      return (a >= ICCM_SADR) && (a < ICCM_SADR + 32'(4 * ICCM_SIZE_WORDS));
   endfunction

   function automatic bit fault_of(logic [31:0] a);
      return (a[31:28] == ICCM_REGION) && !in_iccm(a);
   endfunction

   function automatic logic [31:0] word_of(logic [31:0] a);
      if (in_iccm(a))
         return iccm_img[(a - ICCM_SADR) >> 2];
      if (fault_of(a))
         return '0;                          // Faulting fetch carries no data
      return bus_word(a);
   endfunction

   // Advances to the next falling edge and runs the bus model
   task automatic step();
      @(negedge clk);
      bus_rvalid = 1'b0;
      if (bus_busy) begin
         bus_wait = bus_wait - 1;
         if (bus_wait == 0) begin
            bus_rvalid = 1'b1;
            bus_rdata  = bus_word(bus_pend);
            bus_busy   = 1'b0;
         end
      end
      if (bus_req) begin
         assert (!halted && t_start[31:28] != ICCM_REGION) else begin
            errors++;
            $display("Unexpected bus request to %h during %s", bus_addr, t_name);
         end
         checks++;
         assert (bus_addr == {req_addr[31:2], 2'b00}) else begin
            errors++;
            $display("Fail %s bus_addr expected %h actual %h", t_name,
                     {req_addr[31:2], 2'b00}, bus_addr);
         end
         req_addr = next_addr(req_addr);
         bus_busy = 1'b1;
         bus_pend = bus_addr;
         bus_wait = 1 + $urandom % 6;        // 1 to 6 cycles
      end
   endtask

   task automatic check_word(fetch_addr_t addr, inst_word_t data, logic fault);
      checks++;
      assert (addr == exp_addr[31:1]) else begin
         errors++;
         $display("Fail %s addr expected %h actual %h", t_name, exp_addr, {addr, 1'b0});
      end
      assert (data == word_of(exp_addr)) else begin
         errors++;
         $display("Fail %s data expected %h actual %h", t_name, word_of(exp_addr), data);
      end
      assert (fault == fault_of(exp_addr)) else begin
         errors++;
         $display("Fail %s fault expected %b actual %b", t_name, fault_of(exp_addr), fault);
      end
      exp_addr = next_addr(exp_addr);
   endtask

   // ****************************************
   // One test record
   // ****************************************
   task automatic run_test(int idx);
      int got;
      int hold;
      int want;
      step();                                // Requests seen here still belong to the last test
      t_start  = pat[1 + 4 * idx];
      t_kind   = pat[2 + 4 * idx];
      t_mode   = pat[3 + 4 * idx];
      t_count  = pat[4 + 4 * idx];
      t_name   = $sformatf("test%0d@%h", idx, t_start);
      exp_addr = t_start;
      req_addr = t_start;
      if (t_kind == 1) begin
         halted        = 1'b1;
         flush         = 1'b1;
         flush_noredir = 1'b1;
         flush_path    = t_start[31:1] + 31'h100;   // Halt target that is never fetched
         step();
         flush         = 1'b0;
         flush_noredir = 1'b0;
         repeat (10) begin
            step();
            checks++;
            assert (fb_valid == 2'b00 && !pmu_fetch_stall) else begin
               errors++;
               $display("Fetch buffer filled or stall raised after halt in %s", t_name);
            end
         end
         halted = 1'b0;
         step();
      end
      flush      = 1'b1;
      flush_path = t_start[31:1];
      #1;                                    // BF address settles on the flush target
      checks++;
      assert (fetch_uncacheable_bf == !mrac[2 * t_start[31:28]]) else begin
         errors++;
         $display("Fail %s uncacheable expected %b actual %b", t_name,
                  !mrac[2 * t_start[31:28]], fetch_uncacheable_bf);
      end
      step();
      flush = 1'b0;
      got   = 0;
      hold  = 0;
      while (got < t_count) begin
         want = (t_mode == 0) ? 2 : ((t_mode == 2) ? int'($urandom % 3) : 1);
         if (t_mode == 3 && hold < 20) begin
            want = 0;
            hold++;
            if (hold == 20) begin
               checks++;
               assert (fb_valid == 2'b11 && pmu_fetch_stall) else begin
                  errors++;
                  $display("Fail %s hold expected valid 11 stall 1 actual valid %b stall %b",
                           t_name, fb_valid, pmu_fetch_stall);
               end
            end
         end
         if (want > t_count - got)
            want = t_count - got;
         if (want == 2 && fb_valid != 2'b11)
            want = fb_valid[0];
         if (want == 1 && !fb_valid[0])
            want = 0;
         if (want >= 1)
            check_word(fb_addr0, fb_data0, fb_fault0);
         if (want == 2)
            check_word(fb_addr1, fb_data1, fb_fault1);
         fb_consume1 = (want == 1);
         fb_consume2 = (want == 2);
         got += want;
         step();
      end
      fb_consume1 = 1'b0;                    // Buffer refills and waits for the next flush
      fb_consume2 = 1'b0;
   endtask

   initial begin
      void'($urandom(32'h60616c1e));
      rst_n         = 1'b0;
      flush         = 1'b0;
      flush_noredir = 1'b0;
      flush_path    = '0;
      mrac          = 32'h0000_0010;         // Only region 2 cacheable
      fb_consume1   = 1'b0;
      fb_consume2   = 1'b0;
      iccm_wr_en    = 1'b0;
      iccm_wr_addr  = '0;
      iccm_wr_data  = '0;
      bus_rvalid    = 1'b0;
      bus_rdata     = '0;
      $readmemh("testbench/ifu_patterns.txt", pat);
      for (int i = 0; i < ICCM_SIZE_WORDS; i++)
         iccm_img[i] = (i < 16) ? pat[32 + i] : fill_word(ICCM_SADR + 32'(4 * i));
      for (int t = 0; t < pat[0]; t++)
         wd_cycles += 200 * pat[4 + 4 * t];
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < ICCM_SIZE_WORDS; i++) begin
         step();
         iccm_wr_en   = 1'b1;
         iccm_wr_addr = iccm_idx_t'(i);
         iccm_wr_data = iccm_img[i];
      end
      step();
      iccm_wr_en = 1'b0;
      for (int t = 0; t < pat[0]; t++)
         run_test(t);
      repeat (4) step();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Watchdog allows 200 cycles per expected word
   initial begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge clk);
      $display("Stream stalled, no progress within %0d cycles", wd_cycles);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== rtl/ifu_top.sv ====
`timescale 1ns/10ps
// Instruction fetch front end
// BF control, F stage with ICCM and miss buffer, and the fetch buffer toward the aligner

module ifu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,
   input  ifu_pkg::fetch_addr_t flush_path,
   input  logic                 flush_noredir,
   input  logic [31:0]          mrac,
   input  logic                 fb_consume1,
   input  logic                 fb_consume2,
   input  logic                 iccm_wr_en,
   input  ifu_pkg::iccm_idx_t   iccm_wr_addr,
   input  ifu_pkg::inst_word_t  iccm_wr_data,
   input  logic                 bus_rvalid,
   input  ifu_pkg::inst_word_t  bus_rdata,
   output logic                 bus_req,
   output logic [31:0]          bus_addr,
   output logic [1:0]           fb_valid,
   output ifu_pkg::fetch_addr_t fb_addr0,
   output ifu_pkg::inst_word_t  fb_data0,
   output logic                 fb_fault0,
   output ifu_pkg::fetch_addr_t fb_addr1,
   output ifu_pkg::inst_word_t  fb_data1,
   output logic                 fb_fault1,
   output logic                 fetch_uncacheable_bf,
   output logic                 pmu_fetch_stall
);
   import ifu_pkg::*;

   // BF to F
   fetch_addr_t fetch_addr_bf;
   logic        fetch_req_bf;
   logic        iccm_access_bf;
   logic        region_fault_bf;
   logic        hit_f;

   // Miss path
   logic        miss_start;
   fetch_addr_t miss_addr;
   logic        mb_empty;
   logic        mb_valid;
   fetch_addr_t mb_addr;
   inst_word_t  mb_data;

   // F to fetch buffer
   logic        fb_wr_en;
   fetch_addr_t fb_wr_addr;
   inst_word_t  fb_wr_data;
   logic        fb_wr_fault;

   // F copies inside the control stage are only for its own use
   ifu_fetch_ctl u_fetch_ctl (.fetch_addr_f(), .fetch_req_f(), .*);

   ifu_mem_stage u_mem_stage (.*);

   ifu_miss_buf u_miss_buf (.*);

   ifu_fetch_buf u_fetch_buf (.*);

endmodule

// ==== rtl/ifu_fetch_buf.sv ====
`timescale 1ns/10ps
// Fetch buffer between the F stage and the aligner
// Four-entry shifting queue, the two oldest words are shown to the aligner,
// which consumes one or two per cycle while a new word is appended

module ifu_fetch_buf (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,
   input  logic                 fb_wr_en,
   input  ifu_pkg::fetch_addr_t fb_wr_addr,
   input  ifu_pkg::inst_word_t  fb_wr_data,
   input  logic                 fb_wr_fault,
   input  logic                 fb_consume1,
   input  logic                 fb_consume2,
   output logic [1:0]           fb_valid,      // Bit 0 for entry 0, bit 1 for entry 1
   output ifu_pkg::fetch_addr_t fb_addr0,
   output ifu_pkg::inst_word_t  fb_data0,
   output logic                 fb_fault0,
   output ifu_pkg::fetch_addr_t fb_addr1,
   output ifu_pkg::inst_word_t  fb_data1,
   output logic                 fb_fault1
);
   import ifu_pkg::*;

   fetch_addr_t         q_addr  [FB_DEPTH];   // Entry 0 is the oldest
   inst_word_t          q_data  [FB_DEPTH];
   logic                q_fault [FB_DEPTH];
   logic [FB_CNT_W-1:0] cnt;
   logic [FB_CNT_W-1:0] shift;                // Entries leaving this cycle
   logic [FB_CNT_W-1:0] keep;                 // Entries staying

   always_comb begin
      shift = fb_consume2 ? FB_CNT_W'(2) : (fb_consume1 ? FB_CNT_W'(1) : '0);
      keep  = (shift > cnt) ? '0 : cnt - shift;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         cnt <= '0;
      else if (flush)
         cnt <= '0;
      else
         cnt <= keep + FB_CNT_W'(fb_wr_en);
   end

   // Shift down by the consume, new word lands right after the survivors
   always_ff @(posedge clk) begin
      for (int i = 0; i < FB_DEPTH; i++) begin
         if (fb_wr_en && (keep == FB_CNT_W'(i))) begin
            q_addr[i]  <= fb_wr_addr;
            q_data[i]  <= fb_wr_data;
            q_fault[i] <= fb_wr_fault;
         end else if (i + shift < FB_DEPTH) begin
            q_addr[i]  <= q_addr[i + shift];
            q_data[i]  <= q_data[i + shift];
            q_fault[i] <= q_fault[i + shift];
         end
      end
   end

   assign fb_valid = {cnt > FB_CNT_W'(1), cnt > FB_CNT_W'(0)};

   assign fb_addr0  = q_addr[0];
   assign fb_data0  = q_data[0];
   assign fb_fault0 = q_fault[0];
   assign fb_addr1  = q_addr[1];
   assign fb_data1  = q_data[1];
   assign fb_fault1 = q_fault[1];

endmodule

// ==== rtl/ifu_miss_buf.sv ====
`timescale 1ns/10ps
// Single-entry miss buffer
// Turns a miss into one bus read and keeps the returned word with its address
// until the next fill replaces it

module ifu_miss_buf (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 miss_start,
   input  ifu_pkg::fetch_addr_t miss_addr,
   input  logic                 bus_rvalid,   // Read data strobe
   input  ifu_pkg::inst_word_t  bus_rdata,
   output logic                 bus_req,      // One-cycle request pulse
   output logic [31:0]          bus_addr,     // Word-aligned byte address
   output logic                 mb_empty,
   output logic                 mb_valid,
   output ifu_pkg::fetch_addr_t mb_addr,
   output ifu_pkg::inst_word_t  mb_data
);
   import ifu_pkg::*;

   typedef enum logic {
      MB_IDLE,
      MB_WAIT      // Read issued, response pending
   } mb_state_t;

   mb_state_t   state;
   fetch_addr_t req_addr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= MB_IDLE;
         bus_req  <= 1'b0;
         mb_valid <= 1'b0;
      end else begin
         bus_req <= 1'b0;
         case (state)
            MB_IDLE: if (miss_start) begin
               state   <= MB_WAIT;
               bus_req <= 1'b1;
            end
            MB_WAIT: if (bus_rvalid) begin
               state    <= MB_IDLE;
               mb_valid <= 1'b1;        // Stays valid, later fills overwrite
            end
            default: state <= MB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == MB_IDLE) && miss_start)
         req_addr <= miss_addr;
      if ((state == MB_WAIT) && bus_rvalid) begin
         mb_addr <= req_addr;
         mb_data <= bus_rdata;
      end
   end

   assign bus_addr = {req_addr[31:2], 2'b00};     // Valid with the request pulse
   assign mb_empty = (state == MB_IDLE);

endmodule

// ==== rtl/ifu_mem_stage.sv ====
`timescale 1ns/10ps
// F stage of the fetch pipe
// Holds the ICCM, read in BF with data in F, and decides per request whether the
// word comes from the ICCM, the miss buffer, a fault, or needs a bus fill

module ifu_mem_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   input  ifu_pkg::fetch_addr_t fetch_addr_bf,
   input  logic                 fetch_req_bf,
   input  logic                 iccm_access_bf,
   input  logic                 region_fault_bf,
   input  logic                 flush,
   input  logic                 iccm_wr_en,       // ICCM load port
   input  ifu_pkg::iccm_idx_t   iccm_wr_addr,
   input  ifu_pkg::inst_word_t  iccm_wr_data,
   input  logic                 mb_valid,
   input  ifu_pkg::fetch_addr_t mb_addr,
   input  ifu_pkg::inst_word_t  mb_data,
   output logic                 hit_f,
   output logic                 miss_start,       // One-cycle pulse per new fill
   output ifu_pkg::fetch_addr_t miss_addr,
   output logic                 fb_wr_en,
   output ifu_pkg::fetch_addr_t fb_wr_addr,
   output ifu_pkg::inst_word_t  fb_wr_data,
   output logic                 fb_wr_fault
);
   import ifu_pkg::*;

   inst_word_t  iccm_mem [ICCM_SIZE_WORDS];
   inst_word_t  iccm_rdata_f;
   fetch_addr_t addr_f;
   fetch_addr_t pend_addr;      // Address of the fill in flight
   logic        req_f;
   logic        iccm_f;
   logic        fault_f;
   logic        pend_q;
   logic        fill_done;
   logic        fill_pend;
   logic        mb_hit_f;

   // ****************************************
   // ICCM array
   // ****************************************
   always_ff @(posedge clk) begin
      if (iccm_wr_en)
         iccm_mem[iccm_wr_addr] <= iccm_wr_data;
      if (fetch_req_bf & iccm_access_bf)         // Read only for ICCM fetches
         iccm_rdata_f <= iccm_mem[fetch_addr_bf[ICCM_IDX_W+1:2]];
   end

   // BF to F pipe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_f   <= 1'b0;
         iccm_f  <= 1'b0;
         fault_f <= 1'b0;
         pend_q  <= 1'b0;
      end else begin
         req_f   <= fetch_req_bf;
         iccm_f  <= iccm_access_bf;
         fault_f <= region_fault_bf;
         if (miss_start)
            pend_q <= 1'b1;
         else if (fill_done)
            pend_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      addr_f <= fetch_addr_bf;
      if (miss_start)
         pend_addr <= addr_f;
   end

   // ****************************************
   // Hit decision
   // ****************************************
   // Fill has landed once the miss buffer holds its word
   assign fill_done = pend_q & mb_valid & (mb_addr[31:2] == pend_addr[31:2]);
   assign fill_pend = pend_q & ~fill_done;

   assign mb_hit_f = mb_valid & (mb_addr[31:2] == addr_f[31:2]);
   assign hit_f    = iccm_f | fault_f | mb_hit_f;   // Faults never reach the bus

   // One fill at a time, refetches during a fill stay quiet
   assign miss_start = req_f & ~hit_f & ~flush & ~fill_pend;
   assign miss_addr  = addr_f;

   // Write toward the fetch buffer
   assign fb_wr_en    = req_f & hit_f & ~flush;
   assign fb_wr_addr  = addr_f;
   assign fb_wr_fault = fault_f;
   assign fb_wr_data  = fault_f ? '0 : (iccm_f ? iccm_rdata_f : mb_data);

endmodule

// ==== rtl/ifu_fetch_ctl.sv ====
`timescale 1ns/10ps
// BF stage of the fetch pipe
// Picks the next fetch address, runs the fetch FSM and models fetch buffer occupancy
// so that fetching stops before the buffer overflows

module ifu_fetch_ctl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,                // Redirect from the core
   input  ifu_pkg::fetch_addr_t flush_path,           // Redirect target
   input  logic                 flush_noredir,        // Halt, no fetch at the target
   input  logic                 hit_f,                // F stage word is available
   input  logic                 mb_empty,             // No bus fill outstanding
   input  logic                 fb_consume1,          // Aligner took one word
   input  logic                 fb_consume2,          // Aligner took two words
   input  logic [31:0]          mrac,                 // Two attribute bits per 256 MB region
   output ifu_pkg::fetch_addr_t fetch_addr_bf,
   output logic                 fetch_req_bf,
   output ifu_pkg::fetch_addr_t fetch_addr_f,
   output logic                 fetch_req_f,
   output logic                 iccm_access_bf,       // Served by the ICCM, never by the bus
   output logic                 region_fault_bf,      // ICCM region but beyond the array
   output logic                 fetch_uncacheable_bf,
   output logic                 pmu_fetch_stall
);
   import ifu_pkg::*;

   fetch_state_t      state;
   fetch_state_t      next_state;
   fetch_addr_t       fetch_addr_next;
   logic [FB_DEPTH:0] occ_f;          // One-hot word count, bit k set means k words
   logic [FB_DEPTH:0] occ_ns;
   logic              fb_full_ns;
   logic              fb_full_f;
   logic              sel_next;
   logic              line_wrap;
   logic              miss_f;
   logic              wr_f;
   logic              consume_any;
   logic              fb_left;
   logic              fb_right;
   logic              fb_right2;
   logic              idle;
   logic              wfm;
   logic              goto_idle;
   logic              leave_idle;
   logic              mb_empty_mod;
   logic              in_region;
   logic              in_range;

   // ****************************************
   // Next address
   // ****************************************
   assign sel_next = ~flush & fetch_req_f & hit_f;   // F word delivered, move on

   // Sequential word, bit 1 cleared when a new line starts
   assign fetch_addr_next[31:2] = fetch_addr_f[31:2] + 30'd1;
   assign line_wrap = fetch_addr_next[LINE_INDEX_LO] ^ fetch_addr_f[LINE_INDEX_LO];
   assign fetch_addr_next[1]    = line_wrap ? 1'b0 : fetch_addr_f[1];

   always_comb begin
      fetch_addr_bf = fetch_addr_f;                  // Refetch on a miss or no request
      if (flush)
         fetch_addr_bf = flush_path;
      else if (sel_next)
         fetch_addr_bf = fetch_addr_next;
   end

   // Stop while a fill is pending, or when the pending write fills the buffer
   assign fetch_req_bf = (flush & ~flush_noredir) |
                         (~flush & ~idle & ~(wfm & ~mb_empty) & ~fb_full_ns);

   // ****************************************
   // Fetch FSM
   // ****************************************
   assign miss_f       = fetch_req_f & ~hit_f & ~flush;
   assign goto_idle    = flush & flush_noredir;     // Halt
   assign leave_idle   = flush & ~flush_noredir;
   assign mb_empty_mod = (mb_empty | flush) & ~miss_f;
   assign idle         = (state == IDLE);
   assign wfm          = (state == WFM);

   always_comb begin
      next_state = state;
      case (state)
         IDLE:    if (leave_idle) next_state = FETCH;
         FETCH:   if (miss_f) next_state = WFM;
         WFM:     if (mb_empty_mod) next_state = FETCH;
         default: next_state = IDLE;
      endcase
      if (goto_idle)
         next_state = IDLE;
   end

   // Occupancy model, mirrors the writes and consumes of the fetch buffer
   assign wr_f        = fetch_req_f & hit_f & ~flush;
   assign consume_any = fb_consume1 | fb_consume2;
   assign fb_left     = wr_f & ~consume_any;
   assign fb_right    = (fb_consume1 & ~fb_consume2 & ~wr_f) | (fb_consume2 & wr_f);
   assign fb_right2   = fb_consume2 & ~wr_f;

   always_comb begin
      occ_ns = occ_f;
      if (flush)
         occ_ns = {{FB_DEPTH{1'b0}}, 1'b1};          // Back to empty
      else if (fb_left)
         occ_ns = {occ_f[FB_DEPTH-1:0], 1'b0};
      else if (fb_right)
         occ_ns = {1'b0, occ_f[FB_DEPTH:1]};
      else if (fb_right2)
         occ_ns = {2'b00, occ_f[FB_DEPTH:2]};
   end

   assign fb_full_ns = occ_ns[FB_DEPTH];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= IDLE;
         occ_f        <= {{FB_DEPTH{1'b0}}, 1'b1};
         fb_full_f    <= 1'b0;
         fetch_req_f  <= 1'b0;
         fetch_addr_f <= '0;
      end else begin
         state        <= next_state;
         occ_f        <= occ_ns;
         fb_full_f    <= fb_full_ns;
         fetch_req_f  <= fetch_req_bf;
         fetch_addr_f <= fetch_addr_bf;              // Holds itself when not advancing
      end
   end

   // Counted while waiting for a fill or blocked by a full buffer
   assign pmu_fetch_stall = wfm | (~idle & fb_full_f & ~(consume_any | flush));

   // ****************************************
   // Address attributes
   // ****************************************
   assign in_region = (fetch_addr_bf[31:28] == ICCM_REGION);
   assign in_range  = (fetch_addr_bf[31:ICCM_IDX_W+2] == ICCM_SADR[31:ICCM_IDX_W+2]);

   assign iccm_access_bf       = in_range;
   assign region_fault_bf      = in_region & ~in_range;
   assign fetch_uncacheable_bf = ~mrac[{fetch_addr_bf[31:28], 1'b0}];   // Bit 0 is cacheable

endmodule

// ==== rtl/ifu_pkg.sv ====
// Shared types and constants for the instruction fetch front end
// Every fetch stage imports this package, and the ports use its types by scoped name

package ifu_pkg;

   // Instruction address at halfword granularity, bit 0 implied zero
   typedef logic [31:1] fetch_addr_t;
   typedef logic [31:0] inst_word_t;   // One fetched word

   // Fetch control FSM
   typedef enum logic [1:0] {
      IDLE  = 2'b00,   // No fetching until a redirect
      FETCH = 2'b01,
      STALL = 2'b10,   // Encoding reserved, never entered
      WFM   = 2'b11    // Waiting for a miss fill
   } fetch_state_t;

   // ****************************************
   // ICCM placement
   // ****************************************
   localparam logic [31:0] ICCM_SADR       = 32'hEE00_0000;
   localparam int          ICCM_SIZE_WORDS = 256;   // 1 KB
   localparam int          ICCM_IDX_W      = $clog2(ICCM_SIZE_WORDS);
   localparam logic [3:0]  ICCM_REGION     = 4'hE;  // Top nibble of the ICCM region

   typedef logic [ICCM_IDX_W-1:0] iccm_idx_t;       // Word index into the ICCM

   // Address bit that starts a new fetch line
   localparam int LINE_INDEX_LO = 4;

   // Fetch buffer sizing
   localparam int FB_DEPTH = 4;
   localparam int FB_CNT_W = $clog2(FB_DEPTH) + 1;  // Counts 0 up to FB_DEPTH

endpackage
